// ==== hw/tcore_cpu.sv ====
/* top level of the three-stage core, connects fetch, decode
   and execute to the iomem, write-back and trap ports */
`timescale 1ns/100ps
`default_nettype none

module tcore_cpu
  import tcore_pkg::*;
#(
  parameter word_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // instruction memory
  input  logic      iomem_ready_i,
  input  word_t     iomem_rdata_i,
  output logic      iomem_valid_o,
  output word_t     iomem_addr_o,
  // retirement observation
  output logic      wb_valid_o,
  output word_t     wb_pc_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o,
  output logic      trap_o,
  output word_t     trap_pc_o
);

  pipe1_t pipe1;
  pipe2_t pipe2;
  rf_wr_t rf_wr;

  //////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////

  tcore_fetch #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_fetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .iomem_ready_i (iomem_ready_i),
    .iomem_rdata_i (iomem_rdata_i),
    .iomem_valid_o (iomem_valid_o),
    .iomem_addr_o  (iomem_addr_o),
    .pipe1_o       (pipe1)
  );

  tcore_decode i_decode (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .pipe1_i (pipe1),
    .rf_wr_i (rf_wr),
    .pipe2_o (pipe2)
  );

  // combinational, results appear the cycle after decode loads pipe2
  tcore_execute i_execute (
    .pipe2_i    (pipe2),
    .rf_wr_o    (rf_wr),
    .wb_valid_o (wb_valid_o),
    .wb_pc_o    (wb_pc_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o),
    .trap_o     (trap_o),
    .trap_pc_o  (trap_pc_o)
  );

endmodule

`default_nettype wire

// ==== hw/tcore_decode.sv ====
/* decode stage: register file with write-back bypass, immediates,
   control decoder and the decode-to-execute register */
`timescale 1ns/100ps
`default_nettype none

module tcore_decode
  import tcore_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  pipe1_t pipe1_i,
  input  rf_wr_t rf_wr_i,
  output pipe2_t pipe2_o
);

  word_t      rf_q [31:1];
  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  reg_addr_t  rd_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      imm_i;
  word_t      imm_u;
  alu_op_e    alu_op;
  exc_type_e  exc_type;
  logic       use_imm;
  logic       is_lui;
  pipe2_t     pipe2_q;

  //////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rf_wr_i.we && rf_wr_i.addr != '0) begin
      rf_q[rf_wr_i.addr] <= rf_wr_i.data;
    end
  end

  // x0 reads zero, a write in the same cycle wins over the array
  function automatic word_t read_reg(input reg_addr_t addr);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (rf_wr_i.we && rf_wr_i.addr == addr) begin
      data = rf_wr_i.data;
    end else begin
      data = rf_q[addr];
    end
    return data;
  endfunction

  assign opcode   = pipe1_i.inst[6:0];
  assign rd_addr  = pipe1_i.inst[11:7];
  assign funct3   = pipe1_i.inst[14:12];
  assign rs1_addr = pipe1_i.inst[19:15];
  assign rs2_addr = pipe1_i.inst[24:20];
  assign funct7   = pipe1_i.inst[31:25];

  // reads follow the array and the write port, not only the addresses
  always_comb begin
    rs1_data = read_reg(rs1_addr);
    rs2_data = read_reg(rs2_addr);
  end

  // immediates
  assign imm_i = {{(XLEN-12){pipe1_i.inst[31]}}, pipe1_i.inst[31:20]};
  assign imm_u = {pipe1_i.inst[31:12], 12'b0};

  //////////////////////////////////////////////////
  // control decoder
  //////////////////////////////////////////////////

  always_comb begin
    alu_op   = ADD;
    use_imm  = 1'b0;
    is_lui   = 1'b0;
    exc_type = NO_EXCEPTION;
    unique case (opcode)
      OP: begin
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = ADD;
          {7'h20, 3'b000}: alu_op = SUB;
          {7'h00, 3'b001}: alu_op = SLL;
          {7'h00, 3'b010}: alu_op = SLT;
          {7'h00, 3'b011}: alu_op = SLTU;
          {7'h00, 3'b100}: alu_op = XOR;
          {7'h00, 3'b101}: alu_op = SRL;
          {7'h20, 3'b101}: alu_op = SRA;
          {7'h00, 3'b110}: alu_op = OR;
          {7'h00, 3'b111}: alu_op = AND;
          default:         exc_type = ILLEGAL_INSTR;
        endcase
      end
      OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = ADD;
          3'b010: alu_op = SLT;
          3'b011: alu_op = SLTU;
          3'b100: alu_op = XOR;
          3'b110: alu_op = OR;
          3'b111: alu_op = AND;
          3'b001: begin
            alu_op = SLL;
            if (funct7 != 7'h00) exc_type = ILLEGAL_INSTR;
          end
          default: begin
            // srli / srai share funct3
            alu_op = (funct7 == 7'h20) ? SRA : SRL;
            if (funct7 != 7'h00 && funct7 != 7'h20) exc_type = ILLEGAL_INSTR;
          end
        endcase
      end
      LUI: begin
        alu_op = PASS_B;
        is_lui = 1'b1;
      end
      default: exc_type = ILLEGAL_INSTR;
    endcase
  end

  // payload follows every cycle, only valid needs clearing
  always_ff @(posedge clk_i) begin
    pipe2_q.pc       <= pipe1_i.pc;
    pipe2_q.rd_addr  <= rd_addr;
    pipe2_q.rf_we    <= (exc_type == NO_EXCEPTION) && (rd_addr != '0);
    pipe2_q.alu_op   <= alu_op;
    pipe2_q.op_a     <= rs1_data;
    pipe2_q.op_b     <= is_lui ? imm_u : (use_imm ? imm_i : rs2_data);
    pipe2_q.exc_type <= exc_type;
    if (!rst_ni) begin
      pipe2_q.valid <= 1'b0;
    end else begin
      pipe2_q.valid <= pipe1_i.valid;
    end
  end

  assign pipe2_o = pipe2_q;

  // execute must never send a write to x0
  a_no_x0_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_wr_i.we |-> rf_wr_i.addr != '0);

endmodule

`default_nettype wire

// ==== hw/tcore_execute.sv ====
/* execute stage: ALU, register write port and the write-back
   and trap observation outputs */
`timescale 1ns/100ps
`default_nettype none

module tcore_execute
  import tcore_pkg::*;
(
  input  pipe2_t    pipe2_i,
  output rf_wr_t    rf_wr_o,
  output logic      wb_valid_o,
  output word_t     wb_pc_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o,
  output logic      trap_o,
  output word_t     trap_pc_o
);

  word_t      alu_res;
  logic [4:0] shamt;
  logic       retire;

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  assign shamt = pipe2_i.op_b[4:0];

  always_comb begin
    unique case (pipe2_i.alu_op)
      ADD:     alu_res = pipe2_i.op_a + pipe2_i.op_b;
      SUB:     alu_res = pipe2_i.op_a - pipe2_i.op_b;
      SLL:     alu_res = pipe2_i.op_a << shamt;
      SLT: begin
        alu_res = {{(XLEN-1){1'b0}}, $signed(pipe2_i.op_a) < $signed(pipe2_i.op_b)};
      end
      SLTU: begin
        alu_res = {{(XLEN-1){1'b0}}, pipe2_i.op_a < pipe2_i.op_b};
      end
      XOR:     alu_res = pipe2_i.op_a ^ pipe2_i.op_b;
      SRL:     alu_res = pipe2_i.op_a >> shamt;
      SRA:     alu_res = word_t'($signed(pipe2_i.op_a) >>> shamt);
      OR:      alu_res = pipe2_i.op_a | pipe2_i.op_b;
      AND:     alu_res = pipe2_i.op_a & pipe2_i.op_b;
      PASS_B:  alu_res = pipe2_i.op_b;
      default: alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // write-back and trap
  //////////////////////////////////////////////////

  // illegal words and writes to x0 arrive with rf_we cleared by decode
  assign retire = pipe2_i.valid && pipe2_i.rf_we;

  assign rf_wr_o = '{we: retire, addr: pipe2_i.rd_addr, data: alu_res};

  assign wb_valid_o = retire;
  assign wb_pc_o    = pipe2_i.pc;
  assign wb_rd_o    = pipe2_i.rd_addr;
  assign wb_data_o  = alu_res;

  assign trap_o    = pipe2_i.valid && (pipe2_i.exc_type == ILLEGAL_INSTR);
  assign trap_pc_o = pipe2_i.pc;

  // one instruction leaves per cycle, either retired or trapped
  always_comb begin
    a_wb_trap_excl : assert final (!(wb_valid_o && trap_o));
  end

endmodule

`default_nettype wire

// ==== hw/tcore_fetch.sv ====
/* fetch stage: pc counter, instruction memory request and
   the fetch-to-decode register */
`timescale 1ns/100ps
`default_nettype none

module tcore_fetch
  import tcore_pkg::*;
#(
  parameter word_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   iomem_ready_i,
  input  word_t  iomem_rdata_i,
  output logic   iomem_valid_o,
  output word_t  iomem_addr_o,
  output pipe1_t pipe1_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  word_t        pc_q;
  pipe1_t       pipe1_q;
  logic         handshake;

  assign iomem_valid_o = (state_q == WAIT);
  assign iomem_addr_o  = pc_q;
  assign handshake     = iomem_valid_o && iomem_ready_i;

  // REQ only lasts the first cycle out of reset, after that
  // a new request follows every handshake without a gap
  always_comb begin
    unique case (state_q)
      REQ:     state_d = WAIT;
      WAIT:    state_d = WAIT;
      default: state_d = REQ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= REQ;
      pc_q    <= BOOT_ADDR;
    end else begin
      state_q <= state_d;
      if (handshake) begin
        pc_q <= pc_q + word_t'(4);
      end
    end
  end

  // a bubble goes down the pipe in every cycle without a handshake
  always_ff @(posedge clk_i) begin
    if (handshake) begin
      pipe1_q.pc   <= pc_q;
      pipe1_q.inst <= iomem_rdata_i;
    end
    if (!rst_ni) begin
      pipe1_q.valid <= 1'b0;
    end else begin
      pipe1_q.valid <= handshake;
    end
  end

  assign pipe1_o = pipe1_q;

  // iomem request must hold until the memory takes it
  a_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    iomem_valid_o && !iomem_ready_i |=> iomem_valid_o && $stable(iomem_addr_o));

endmodule

`default_nettype wire

// ==== hw/tcore_pkg.sv ====
/* widths, opcodes, enums and pipeline packets shared by
   the fetch, decode and execute stages */
`default_nettype none

package tcore_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes of the supported subset
  localparam opcode_t OP     = 7'b0110011;
  localparam opcode_t OP_IMM = 7'b0010011;
  localparam opcode_t LUI    = 7'b0110111;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B  // result is op_b, used by lui
  } alu_op_e;

  typedef enum logic {
    NO_EXCEPTION,
    ILLEGAL_INSTR
  } exc_type_e;

  // instruction fetch FSM
  typedef enum logic {
    REQ,
    WAIT
  } fetch_state_e;

  //////////////////////////////////////////////////
  // pipeline packets
  //////////////////////////////////////////////////

  // fetch to decode
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } pipe1_t;

  // decode to execute
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd_addr;
    logic      rf_we;
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    exc_type_e exc_type;
  } pipe2_t;

  // register write from execute back into decode
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sources.f --top-module tb_tcore_cpu -o sim_tcore > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tcore > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

// ==== include/tb_rv_model.svh ====
/* testbench helpers: galois lfsr, random rv32i instruction encoder
   and the reference model of the supported subset */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// galois form, taps of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_q[0]};
    lfsr_q = lfsr_step(lfsr_q);
  end
  return r;
endfunction

// half of the sources reuse the last rd, so the bypass sees traffic
function automatic reg_addr_t pick_src();
  reg_addr_t r;
  if (rand_bits(1) == 32'd1) begin
    r = prev_rd;
  end else begin
    r = reg_addr_t'(rand_bits(5));
  end
  return r;
endfunction

function automatic word_t gen_inst();
  word_t      inst;
  word_t      r;
  logic [2:0] f3;
  logic [6:0] f7;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  rd  = reg_addr_t'(rand_bits(5));
  f3  = 3'(rand_bits(3));
  rs1 = pick_src();
  rs2 = pick_src();
  if (rand_bits(4) == 32'd0) begin
    // load opcode, outside the subset
    r    = rand_bits(25);
    inst = {r[24:0], 7'b0000011};
  end else begin
    case (2'(rand_bits(2)))
      2'd0, 2'd1: begin
        f7 = 7'h00;
        if ((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1) == 32'd1) begin
          f7 = 7'h20;
        end
        inst = {f7, rs2, rs1, f3, rd, OP};
      end
      2'd2: begin
        r = rand_bits(12);
        if (f3 == 3'b001) begin
          r[11:5] = 7'h00;
        end else if (f3 == 3'b101) begin
          r[11:5] = (rand_bits(1) == 32'd1) ? 7'h20 : 7'h00;
        end
        inst = {r[11:0], rs1, f3, rd, OP_IMM};
      end
      default: begin
        r    = rand_bits(20);
        inst = {r[19:0], rd, LUI};
      end
    endcase
  end
  prev_rd = rd;
  return inst;
endfunction

function automatic logic ref_legal(input word_t inst);
  logic [6:0] f7;
  logic [2:0] f3;
  logic       ok;
  f7 = inst[31:25];
  f3 = inst[14:12];
  case (inst[6:0])
    LUI:     ok = 1'b1;
    OP:      ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
    OP_IMM: begin
      if (f3 == 3'b001) begin
        ok = f7 == 7'h00;
      end else if (f3 == 3'b101) begin
        ok = f7 == 7'h00 || f7 == 7'h20;
      end else begin
        ok = 1'b1;
      end
    end
    default: ok = 1'b0;
  endcase
  return ok;
endfunction

// rv32i semantics of a legal word, given its two source values
function automatic word_t ref_result(input word_t inst, input word_t a, input word_t rs2_val);
  word_t                   b;
  word_t                   res;
  word_t                   sra;
  logic signed [XLEN-1:0]  sa;
  logic                    alt;
  b   = (inst[6:0] == OP) ? rs2_val : {{20{inst[31]}}, inst[31:20]};
  sa  = a;
  sra = sa >>> b[4:0];
  // bit 30 selects sub and sra, but never for an addi immediate
  alt = inst[30] && (inst[6:0] == OP || inst[14:12] == 3'b101);
  case (inst[14:12])
    3'b000:  res = alt ? a - b : a + b;
    3'b001:  res = a << b[4:0];
    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
    3'b011:  res = {31'b0, a < b};
    3'b100:  res = a ^ b;
    3'b101:  res = alt ? sra : a >> b[4:0];
    3'b110:  res = a | b;
    default: res = a & b;
  endcase
  if (inst[6:0] == LUI) begin
    res = {inst[31:12], 12'h000};
  end
  return res;
endfunction

`endif

// ==== sim/tb_tcore_cpu.sv ====
/* testbench of the three-stage core: clock, reset, random memory
   responder, model checker, compare tasks and watchdog */
`timescale 1ns/100ps
`default_nettype none

module tb_tcore_cpu
  import tcore_pkg::*;
;

  localparam word_t BOOT_ADDR    = 32'h0000_2000;
  localparam int    N_INSTR      = 300;
  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 16;
  localparam int    WATCHDOG_NS  = (N_INSTR * 6 + RESET_CYCLES) * CLK_PERIOD;

  typedef struct packed {
    int    due;
    word_t pc;
    word_t inst;
  } fetch_rec_t;

  logic      clk;
  logic      rst_n;
  logic      iomem_ready = 1'b0;
  word_t     iomem_rdata = '0;
  logic      iomem_valid;
  word_t     iomem_addr;
  logic      wb_valid;
  word_t     wb_pc;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      trap;
  word_t     trap_pc;

  logic [31:0] lfsr_q;
  reg_addr_t   prev_rd;
  logic [1:0]  wait_q = '0;
  logic [1:0]  delay;
  word_t       prog [N_INSTR];
  word_t       model_rf [32];
  fetch_rec_t  inflight_q [$];
  word_t       next_pc = BOOT_ADDR;
  int          cycle = 0;
  int          n_fetched = 0;
  int          n_done = 0;
  int          value_errs = 0;
  int          other_errs = 0;

  `include "tb_rv_model.svh"

  tcore_cpu #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_tcore_cpu (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .iomem_ready_i (iomem_ready),
    .iomem_rdata_i (iomem_rdata),
    .iomem_valid_o (iomem_valid),
    .iomem_addr_o  (iomem_addr),
    .wb_valid_o    (wb_valid),
    .wb_pc_o       (wb_pc),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .trap_o        (trap),
    .trap_pc_o     (trap_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  //////////////////////////////////////////////////
  // memory responder
  //////////////////////////////////////////////////

  // past the program the core only sees addi x0, x0, 0
  function automatic word_t prog_word(input word_t addr);
    int idx;
    idx = int'((addr - BOOT_ADDR) >> 2);
    return (idx >= 0 && idx < N_INSTR) ? prog[idx] : 32'h0000_0013;
  endfunction

  // every new request gets a fresh wait of 0 to 3 cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      iomem_ready <= 1'b0;
      wait_q      <= '0;
    end else if (!iomem_valid || iomem_ready) begin
      delay = 2'(rand_bits(2));
      wait_q      <= delay;
      iomem_ready <= (delay == 2'd0);
    end else begin
      wait_q      <= wait_q - 2'd1;
      iomem_ready <= (wait_q == 2'd1);
    end
    iomem_rdata <= prog_word((iomem_valid && iomem_ready) ? iomem_addr + 32'd4 : iomem_addr);
  end

  //////////////////////////////////////////////////
  // compare tasks and checker
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERROR %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERROR %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle);
    end
  endtask

  task automatic check_trap(input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERROR trap_pc_o: got 0x%h, expected 0x%h (cycle %0d)", got, exp, cycle);
    end
  endtask

  // each fetched word is due exactly two cycles after its handshake
  task automatic retire_check();
    fetch_rec_t rec;
    word_t      res;
    reg_addr_t  rd;
    if (inflight_q.size() != 0 && inflight_q[0].due == cycle) begin
      rec = inflight_q.pop_front();
      rd  = rec.inst[11:7];
      if (!ref_legal(rec.inst)) begin
        if (!trap || wb_valid) begin
          other_errs++;
          $display("illegal word %h at pc %h did not trap alone", rec.inst, rec.pc);
        end else begin
          check_trap(trap_pc, rec.pc);
        end
      end else begin
        res = ref_result(rec.inst, model_rf[rec.inst[19:15]], model_rf[rec.inst[24:20]]);
        if (rd == '0) begin
          if (wb_valid || trap) begin
            other_errs++;
            $display("instruction at pc %h writes x0 but was reported", rec.pc);
          end
        end else if (!wb_valid || trap) begin
          other_errs++;
          $display("instruction at pc %h was not retired", rec.pc);
        end else begin
          check_word("wb_pc_o", wb_pc, rec.pc);
          check_reg("wb_rd_o", wb_rd, rd);
          check_word("wb_data_o", wb_data, res);
        end
        if (rd != '0) begin
          model_rf[rd] = res;
        end
      end
      n_done++;
    end else if (wb_valid || trap) begin
      other_errs++;
      $display("retirement at cycle %0d with no instruction due", cycle);
    end
  endtask

  // sampled on the falling edge, away from the stimulus
  always @(negedge clk) begin
    if (!rst_n) begin
      if (iomem_valid || wb_valid || trap) begin
        other_errs++;
        $display("outputs active during reset at cycle %0d", cycle);
      end
    end else begin
      retire_check();
      if (iomem_valid && iomem_ready && n_fetched < N_INSTR) begin
        check_word("iomem_addr_o", iomem_addr, next_pc);
        inflight_q.push_back('{due: cycle + 2, pc: iomem_addr, inst: iomem_rdata});
        next_pc = next_pc + 32'd4;
        n_fetched++;
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    rst_n   = 1'b0;
    lfsr_q  = 32'd2;
    prev_rd = '0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    for (int i = 0; i < N_INSTR; i++) begin
      prog[i] = gen_inst();
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    wait (n_done == N_INSTR);
    repeat (2) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, %0d of %0d instructions checked", n_done, N_INSTR);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/tcore_pkg.sv
hw/tcore_fetch.sv
hw/tcore_decode.sv
hw/tcore_execute.sv
hw/tcore_cpu.sv
sim/tb_tcore_cpu.sv
